/* axi_sram.sv */
module axi_sram
  import mem_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        io_master_awvalid,
  input  logic [3:0]  io_master_awid,
  input  logic [31:0] io_master_awaddr,
  input  logic [7:0]  io_master_awlen,
  input  logic [2:0]  io_master_awsize,
  input  logic [1:0]  io_master_awburst,
  output logic        io_master_awready,
  input  logic        io_master_wvalid,
  input  logic [31:0] io_master_wdata,
  input  logic [3:0]  io_master_wstrb,
  input  logic        io_master_wlast,
  output logic        io_master_wready,
  output logic        io_master_bvalid,
  input  logic        io_master_bready,
  output logic [3:0]  io_master_bid,
  output logic [1:0]  io_master_bresp,
  input  logic        io_master_arvalid,
  input  logic [3:0]  io_master_arid,
  input  logic [31:0] io_master_araddr,
  input  logic [7:0]  io_master_arlen,
  input  logic [2:0]  io_master_arsize,
  input  logic [1:0]  io_master_arburst,
  output logic        io_master_arready,
  output logic        io_master_rvalid,
  input  logic        io_master_rready,
  output logic [31:0] io_master_rdata,
  output logic [3:0]  io_master_rid,
  output logic [1:0]  io_master_rresp,
  output logic        io_master_rlast
);

  typedef enum logic {RD_IDLE, RD_BURST} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

  logic [31:0] mem [SRAM_WORDS];
  rd_state_e   rd_state;
  wr_state_e   wr_state;
  logic [31:0] rd_addr;
  logic [7:0]  rd_left;
  logic [1:0]  rd_burst;
  logic [31:0] wr_addr;
  logic [1:0]  wr_burst;
  logic        wr_err;
  logic        rd_ok;
  logic        wr_ok;

  function automatic logic in_range(input logic [31:0] addr);
    return (addr - SRAM_BASE) < 32'(SRAM_WORDS * 4);   // Wraps below base
  endfunction

  assign rd_ok = in_range(rd_addr);
  assign wr_ok = in_range(wr_addr);

  // ========================================
  // Read burst
  // ========================================
  assign io_master_arready = rd_state == RD_IDLE;
  assign io_master_rvalid  = rd_state == RD_BURST;
  assign io_master_rlast   = rd_left == 8'd0;
  assign io_master_rdata   = rd_ok ? mem[rd_addr[SRAM_INDEX_W+1:2]] : '0;
  assign io_master_rresp   = rd_ok ? RESP_OKAY : RESP_DECERR;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= RD_IDLE;
    end else if (io_master_arvalid && io_master_arready) begin
      rd_state <= RD_BURST;
    end else if (io_master_rvalid && io_master_rready && io_master_rlast) begin
      rd_state <= RD_IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (io_master_arvalid && io_master_arready) begin
      rd_addr       <= io_master_araddr;
      rd_left       <= io_master_arlen;
      rd_burst      <= io_master_arburst;
      io_master_rid <= io_master_arid;
    end else if (io_master_rvalid && io_master_rready) begin
      rd_left <= rd_left - 8'd1;
      rd_addr <= rd_addr + ((rd_burst == BURST_FIXED) ? 32'd0 : 32'd4);  // WRAP runs as INCR
    end
  end

  // ========================================
  // Write burst
  // ========================================
  assign io_master_awready = wr_state == WR_IDLE;
  assign io_master_wready  = wr_state == WR_DATA;
  assign io_master_bvalid  = wr_state == WR_RESP;
  assign io_master_bresp   = wr_err ? RESP_DECERR : RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE:  if (io_master_awvalid) wr_state <= WR_DATA;
        WR_DATA:  if (io_master_wvalid && io_master_wlast) wr_state <= WR_RESP;
        default:  if (io_master_bready) wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (io_master_awvalid && io_master_awready) begin
      wr_addr       <= io_master_awaddr;
      wr_burst      <= io_master_awburst;
      wr_err        <= 1'b0;
      io_master_bid <= io_master_awid;
    end else if (io_master_wvalid && io_master_wready) begin
      wr_err  <= wr_err | !wr_ok;                     // Any bad beat fails the burst
      wr_addr <= wr_addr + ((wr_burst == BURST_FIXED) ? 32'd0 : 32'd4);
      for (int i = 0; i < 4; i++) begin
        if (wr_ok && io_master_wstrb[i]) begin
          mem[wr_addr[SRAM_INDEX_W+1:2]][8*i +: 8] <= io_master_wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

/* axi_xbar.sv */
module axi_xbar
  import mem_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // Instruction cache, read only
  input  logic        icache_ar_valid,
  input  logic [31:0] icache_ar_addr,
  input  logic [3:0]  icache_ar_id,
  input  logic [7:0]  icache_ar_len,
  input  logic [2:0]  icache_ar_size,
  input  logic [1:0]  icache_ar_burst,
  input  logic        icache_r_ready,
  output logic        icache_ar_ready,
  output logic        icache_r_valid,
  output logic [31:0] icache_r_data,
  output logic [1:0]  icache_r_resp,
  output logic        icache_r_last,
  output logic [3:0]  icache_r_id,
  // Load/store unit
  input  logic        lsu_ar_valid,
  input  logic [31:0] lsu_ar_addr,
  input  logic [3:0]  lsu_ar_id,
  input  logic [7:0]  lsu_ar_len,
  input  logic [2:0]  lsu_ar_size,
  input  logic [1:0]  lsu_ar_burst,
  input  logic        lsu_r_ready,
  input  logic        lsu_aw_valid,
  input  logic [31:0] lsu_aw_addr,
  input  logic [3:0]  lsu_aw_id,
  input  logic [7:0]  lsu_aw_len,
  input  logic [2:0]  lsu_aw_size,
  input  logic [1:0]  lsu_aw_burst,
  input  logic        lsu_w_valid,
  input  logic [31:0] lsu_w_data,
  input  logic [3:0]  lsu_w_strb,
  input  logic        lsu_w_last,
  input  logic        lsu_b_ready,
  output logic        lsu_ar_ready,
  output logic        lsu_r_valid,
  output logic [31:0] lsu_r_data,
  output logic [1:0]  lsu_r_resp,
  output logic        lsu_r_last,
  output logic [3:0]  lsu_r_id,
  output logic        lsu_aw_ready,
  output logic        lsu_w_ready,
  output logic        lsu_b_valid,
  output logic [1:0]  lsu_b_resp,
  output logic [3:0]  lsu_b_id,
  // External master port to the SRAM
  input  logic        io_master_awready,
  input  logic        io_master_wready,
  input  logic        io_master_bvalid,
  input  logic [3:0]  io_master_bid,
  input  logic [1:0]  io_master_bresp,
  input  logic        io_master_arready,
  input  logic        io_master_rvalid,
  input  logic [31:0] io_master_rdata,
  input  logic [3:0]  io_master_rid,
  input  logic [1:0]  io_master_rresp,
  input  logic        io_master_rlast,
  output logic        io_master_awvalid,
  output logic [3:0]  io_master_awid,
  output logic [31:0] io_master_awaddr,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  output logic        io_master_wvalid,
  output logic [31:0] io_master_wdata,
  output logic [3:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  output logic        io_master_arvalid,
  output logic [3:0]  io_master_arid,
  output logic [31:0] io_master_araddr,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready
);

  logic        clint_ar_valid;
  logic [31:0] clint_ar_addr;
  logic [3:0]  clint_ar_id;
  logic [7:0]  clint_ar_len;
  logic [2:0]  clint_ar_size;
  logic [1:0]  clint_ar_burst;
  logic        clint_ar_ready;
  logic        clint_r_valid;
  logic        clint_r_ready;
  logic [31:0] clint_r_data;
  logic [1:0]  clint_r_resp;
  logic        clint_r_last;
  logic [3:0]  clint_r_id;
  logic        clint_aw_valid;
  logic [31:0] clint_aw_addr;
  logic [3:0]  clint_aw_id;
  logic [7:0]  clint_aw_len;
  logic [2:0]  clint_aw_size;
  logic [1:0]  clint_aw_burst;
  logic        clint_aw_ready;
  logic        clint_w_valid;
  logic [31:0] clint_w_data;
  logic [3:0]  clint_w_strb;
  logic        clint_w_last;
  logic        clint_w_ready;
  logic        clint_b_valid;
  logic        clint_b_ready;
  logic [1:0]  clint_b_resp;
  logic [3:0]  clint_b_id;

  grant_e      grant;
  logic        lsu_req;
  logic [31:0] lsu_addr;
  logic        lsu_to_clint;
  logic        sel_icache;
  logic        sel_lsu_sram;
  logic        sel_clint;

  // ========================================
  // Grant and decode
  // ========================================
  assign lsu_req      = lsu_ar_valid | lsu_aw_valid | lsu_w_valid;
  assign lsu_addr     = lsu_ar_valid ? lsu_ar_addr : lsu_aw_addr;  // Write data follows aw addr
  assign lsu_to_clint = (lsu_addr == MTIME_LO_ADDR) || (lsu_addr == MTIME_HI_ADDR);
  assign sel_icache   = grant == GRANT_ICACHE_SRAM;
  assign sel_lsu_sram = grant == GRANT_LSU_SRAM;
  assign sel_clint    = grant == GRANT_LSU_CLINT;

  always_ff @(posedge clock) begin
    if (reset) begin
      grant <= GRANT_IDLE;
    end else begin
      case (grant)
        GRANT_IDLE: begin
          if (icache_ar_valid) begin
            grant <= GRANT_ICACHE_SRAM;                   // Icache wins a tie
          end else if (lsu_req) begin
            grant <= lsu_to_clint ? GRANT_LSU_CLINT : GRANT_LSU_SRAM;
          end
        end
        GRANT_ICACHE_SRAM: begin
          if (io_master_rvalid && io_master_rready && io_master_rlast) begin
            grant <= GRANT_IDLE;
          end
        end
        GRANT_LSU_SRAM: begin
          if ((io_master_rvalid && io_master_rready) || (io_master_bvalid && io_master_bready)) begin
            grant <= GRANT_IDLE;
          end
        end
        default: begin
          if ((clint_r_valid && clint_r_ready) || (clint_b_valid && clint_b_ready)) begin
            grant <= GRANT_IDLE;
          end
        end
      endcase
    end
  end

  // ========================================
  // Request routing
  // ========================================
  always_comb begin
    io_master_arvalid = sel_icache ? icache_ar_valid : sel_lsu_sram & lsu_ar_valid;
    io_master_araddr  = sel_icache ? icache_ar_addr : sel_lsu_sram ? lsu_ar_addr : '0;
    io_master_arid    = sel_icache ? icache_ar_id : sel_lsu_sram ? lsu_ar_id : '0;
    io_master_arlen   = sel_icache ? icache_ar_len : sel_lsu_sram ? lsu_ar_len : '0;
    io_master_arsize  = sel_icache ? icache_ar_size : sel_lsu_sram ? lsu_ar_size : '0;
    io_master_arburst = sel_icache ? icache_ar_burst : sel_lsu_sram ? lsu_ar_burst : '0;
    io_master_rready  = sel_icache ? icache_r_ready : sel_lsu_sram & lsu_r_ready;
    io_master_awvalid = sel_lsu_sram & lsu_aw_valid;    // Icache never writes
    io_master_awaddr  = sel_lsu_sram ? lsu_aw_addr : '0;
    io_master_awid    = sel_lsu_sram ? lsu_aw_id : '0;
    io_master_awlen   = sel_lsu_sram ? lsu_aw_len : '0;
    io_master_awsize  = sel_lsu_sram ? lsu_aw_size : '0;
    io_master_awburst = sel_lsu_sram ? lsu_aw_burst : '0;
    io_master_wvalid  = sel_lsu_sram & lsu_w_valid;
    io_master_wdata   = sel_lsu_sram ? lsu_w_data : '0;
    io_master_wstrb   = sel_lsu_sram ? lsu_w_strb : '0;
    io_master_wlast   = sel_lsu_sram & lsu_w_last;
    io_master_bready  = sel_lsu_sram & lsu_b_ready;
  end

  always_comb begin
    clint_ar_valid = sel_clint & lsu_ar_valid;
    clint_ar_addr  = sel_clint ? lsu_ar_addr : '0;
    clint_ar_id    = sel_clint ? lsu_ar_id : '0;
    clint_ar_len   = sel_clint ? lsu_ar_len : '0;
    clint_ar_size  = sel_clint ? lsu_ar_size : '0;
    clint_ar_burst = sel_clint ? lsu_ar_burst : '0;
    clint_r_ready  = sel_clint & lsu_r_ready;
    clint_aw_valid = sel_clint & lsu_aw_valid;
    clint_aw_addr  = sel_clint ? lsu_aw_addr : '0;
    clint_aw_id    = sel_clint ? lsu_aw_id : '0;
    clint_aw_len   = sel_clint ? lsu_aw_len : '0;
    clint_aw_size  = sel_clint ? lsu_aw_size : '0;
    clint_aw_burst = sel_clint ? lsu_aw_burst : '0;
    clint_w_valid  = sel_clint & lsu_w_valid;
    clint_w_data   = sel_clint ? lsu_w_data : '0;
    clint_w_strb   = sel_clint ? lsu_w_strb : '0;
    clint_w_last   = sel_clint & lsu_w_last;
    clint_b_ready  = sel_clint & lsu_b_ready;
  end

  // ========================================
  // Response routing
  // ========================================
  always_comb begin
    icache_ar_ready = sel_icache & io_master_arready;
    icache_r_valid  = sel_icache & io_master_rvalid;
    icache_r_data   = sel_icache ? io_master_rdata : '0;
    icache_r_resp   = sel_icache ? io_master_rresp : '0;
    icache_r_last   = sel_icache & io_master_rlast;
    icache_r_id     = sel_icache ? io_master_rid : '0;
    lsu_ar_ready = sel_lsu_sram ? io_master_arready : sel_clint & clint_ar_ready;
    lsu_r_valid  = sel_lsu_sram ? io_master_rvalid : sel_clint & clint_r_valid;
    lsu_r_data   = sel_lsu_sram ? io_master_rdata : sel_clint ? clint_r_data : '0;
    lsu_r_resp   = sel_lsu_sram ? io_master_rresp : sel_clint ? clint_r_resp : '0;
    lsu_r_last   = sel_lsu_sram ? io_master_rlast : sel_clint & clint_r_last;
    lsu_r_id     = sel_lsu_sram ? io_master_rid : sel_clint ? clint_r_id : '0;
    lsu_aw_ready = sel_lsu_sram ? io_master_awready : sel_clint & clint_aw_ready;
    lsu_w_ready  = sel_lsu_sram ? io_master_wready : sel_clint & clint_w_ready;
    lsu_b_valid  = sel_lsu_sram ? io_master_bvalid : sel_clint & clint_b_valid;
    lsu_b_resp   = sel_lsu_sram ? io_master_bresp : sel_clint ? clint_b_resp : '0;
    lsu_b_id     = sel_lsu_sram ? io_master_bid : sel_clint ? clint_b_id : '0;
  end

  clint_timer u_clint (.*);

endmodule

/* clint_timer.sv */
module clint_timer
  import mem_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        clint_ar_valid,
  input  logic [31:0] clint_ar_addr,
  input  logic [3:0]  clint_ar_id,
  input  logic [7:0]  clint_ar_len,
  input  logic [2:0]  clint_ar_size,
  input  logic [1:0]  clint_ar_burst,
  output logic        clint_ar_ready,
  output logic        clint_r_valid,
  input  logic        clint_r_ready,
  output logic [31:0] clint_r_data,
  output logic [1:0]  clint_r_resp,
  output logic        clint_r_last,
  output logic [3:0]  clint_r_id,
  input  logic        clint_aw_valid,
  input  logic [31:0] clint_aw_addr,
  input  logic [3:0]  clint_aw_id,
  input  logic [7:0]  clint_aw_len,
  input  logic [2:0]  clint_aw_size,
  input  logic [1:0]  clint_aw_burst,
  output logic        clint_aw_ready,
  input  logic        clint_w_valid,
  input  logic [31:0] clint_w_data,
  input  logic [3:0]  clint_w_strb,
  input  logic        clint_w_last,
  output logic        clint_w_ready,
  output logic        clint_b_valid,
  input  logic        clint_b_ready,
  output logic [1:0]  clint_b_resp,
  output logic [3:0]  clint_b_id
);

  logic [63:0] mtime;
  logic        aw_pending;
  logic        wr_hi;
  logic [31:0] old_word;
  logic [31:0] new_word;
  logic        ar_fire;
  logic        aw_fire;
  logic        w_fire;

  assign ar_fire = clint_ar_valid && clint_ar_ready;
  assign aw_fire = clint_aw_valid && clint_aw_ready;
  assign w_fire  = clint_w_valid && clint_w_ready;

  assign clint_ar_ready = !clint_r_valid;
  assign clint_aw_ready = !aw_pending && !clint_b_valid;
  assign clint_w_ready  = aw_pending;
  assign clint_r_resp   = RESP_OKAY;
  assign clint_r_last   = 1'b1;                 // Single beat only
  assign clint_b_resp   = RESP_OKAY;

  // Byte merge into the addressed half of mtime
  assign old_word = wr_hi ? mtime[63:32] : mtime[31:0];
  always_comb begin
    new_word = old_word;
    for (int i = 0; i < 4; i++) begin
      if (clint_w_strb[i]) begin
        new_word[8*i +: 8] = clint_w_data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime         <= '0;
      aw_pending    <= 1'b0;
      clint_r_valid <= 1'b0;
      clint_b_valid <= 1'b0;
    end else begin
      if (w_fire) begin
        mtime <= wr_hi ? {new_word, mtime[31:0]} : {mtime[63:32], new_word};
      end else begin
        mtime <= mtime + 64'd1;
      end
      if (ar_fire) begin
        clint_r_valid <= 1'b1;
      end else if (clint_r_ready) begin
        clint_r_valid <= 1'b0;
      end
      if (aw_fire) begin
        aw_pending <= 1'b1;
      end else if (w_fire) begin
        aw_pending <= 1'b0;
      end
      if (w_fire) begin
        clint_b_valid <= 1'b1;
      end else if (clint_b_ready) begin
        clint_b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      clint_r_data <= (clint_ar_addr == MTIME_HI_ADDR) ? mtime[63:32] : mtime[31:0];
      clint_r_id   <= clint_ar_id;
    end
    if (aw_fire) begin
      wr_hi      <= clint_aw_addr == MTIME_HI_ADDR;
      clint_b_id <= clint_aw_id;
    end
  end

endmodule

/* mem_pkg.sv */
package mem_pkg;

  // ========================================
  // Bus encodings
  // ========================================
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } burst_e;

  typedef enum logic [1:0] {
    GRANT_IDLE        = 2'd0,
    GRANT_ICACHE_SRAM = 2'd1,
    GRANT_LSU_SRAM    = 2'd2,
    GRANT_LSU_CLINT   = 2'd3
  } grant_e;

  // ========================================
  // Address map
  // ========================================
  localparam logic [31:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [31:0] MTIME_HI_ADDR = 32'h0200_bffc;
  localparam logic [31:0] SRAM_BASE     = 32'h8000_0000;
  localparam int          SRAM_WORDS    = 1024;         // 4 KB of 32-bit words
  localparam int          SRAM_INDEX_W  = 10;

endpackage

/* mem_subsystem.sv */
module mem_subsystem (
  input  logic        clock,
  input  logic        reset,
  input  logic        icache_ar_valid,
  input  logic [31:0] icache_ar_addr,
  input  logic [3:0]  icache_ar_id,
  input  logic [7:0]  icache_ar_len,
  input  logic [2:0]  icache_ar_size,
  input  logic [1:0]  icache_ar_burst,
  input  logic        icache_r_ready,
  output logic        icache_ar_ready,
  output logic        icache_r_valid,
  output logic [31:0] icache_r_data,
  output logic [1:0]  icache_r_resp,
  output logic        icache_r_last,
  output logic [3:0]  icache_r_id,
  input  logic        lsu_ar_valid,
  input  logic [31:0] lsu_ar_addr,
  input  logic [3:0]  lsu_ar_id,
  input  logic [7:0]  lsu_ar_len,
  input  logic [2:0]  lsu_ar_size,
  input  logic [1:0]  lsu_ar_burst,
  input  logic        lsu_r_ready,
  input  logic        lsu_aw_valid,
  input  logic [31:0] lsu_aw_addr,
  input  logic [3:0]  lsu_aw_id,
  input  logic [7:0]  lsu_aw_len,
  input  logic [2:0]  lsu_aw_size,
  input  logic [1:0]  lsu_aw_burst,
  input  logic        lsu_w_valid,
  input  logic [31:0] lsu_w_data,
  input  logic [3:0]  lsu_w_strb,
  input  logic        lsu_w_last,
  input  logic        lsu_b_ready,
  output logic        lsu_ar_ready,
  output logic        lsu_r_valid,
  output logic [31:0] lsu_r_data,
  output logic [1:0]  lsu_r_resp,
  output logic        lsu_r_last,
  output logic [3:0]  lsu_r_id,
  output logic        lsu_aw_ready,
  output logic        lsu_w_ready,
  output logic        lsu_b_valid,
  output logic [1:0]  lsu_b_resp,
  output logic [3:0]  lsu_b_id
);

  // ========================================
  // Crossbar to SRAM
  // ========================================
  logic        io_master_awvalid;
  logic        io_master_awready;
  logic [3:0]  io_master_awid;
  logic [31:0] io_master_awaddr;
  logic [7:0]  io_master_awlen;
  logic [2:0]  io_master_awsize;
  logic [1:0]  io_master_awburst;
  logic        io_master_wvalid;
  logic        io_master_wready;
  logic [31:0] io_master_wdata;
  logic [3:0]  io_master_wstrb;
  logic        io_master_wlast;
  logic        io_master_bvalid;
  logic        io_master_bready;
  logic [3:0]  io_master_bid;
  logic [1:0]  io_master_bresp;
  logic        io_master_arvalid;
  logic        io_master_arready;
  logic [3:0]  io_master_arid;
  logic [31:0] io_master_araddr;
  logic [7:0]  io_master_arlen;
  logic [2:0]  io_master_arsize;
  logic [1:0]  io_master_arburst;
  logic        io_master_rvalid;
  logic        io_master_rready;
  logic [31:0] io_master_rdata;
  logic [3:0]  io_master_rid;
  logic [1:0]  io_master_rresp;
  logic        io_master_rlast;

  axi_xbar u_xbar (.*);

  axi_sram u_sram (.*);

endmodule

/* sim.f */
+incdir+.
mem_pkg.sv
clint_timer.sv
axi_sram.sv
axi_xbar.sv
mem_subsystem.sv
tb_mem_subsystem.sv

/* tb_bus_tasks.svh */
// ========================================
// Beats captured by the icache burst task
// ========================================
logic [31:0] beat_data[$];
resp_e       beat_resp[$];
logic        beat_last[$];
logic [3:0]  beat_id[$];

task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [3:0] id,
                         output resp_e resp, output logic [3:0] bid);
  lsu_aw_valid = 1'b1;
  lsu_aw_addr  = addr;
  lsu_aw_id    = id;
  lsu_aw_len   = 8'd0;
  lsu_aw_size  = 3'd2;
  lsu_aw_burst = BURST_INCR;
  @(negedge clock);
  while (!lsu_aw_ready) @(negedge clock);
  @(posedge clock);
  #1;
  lsu_aw_valid = 1'b0;
  lsu_w_valid  = 1'b1;                                // Single beat, so last is set
  lsu_w_data   = data;
  lsu_w_strb   = strb;
  lsu_w_last   = 1'b1;
  @(negedge clock);
  while (!lsu_w_ready) @(negedge clock);
  @(posedge clock);
  #1;
  lsu_w_valid = 1'b0;
  lsu_w_last  = 1'b0;
  lsu_b_ready = 1'b1;
  @(negedge clock);
  while (!lsu_b_valid) @(negedge clock);
  resp = resp_e'(lsu_b_resp);
  bid  = lsu_b_id;
  @(posedge clock);
  #1;
  lsu_b_ready = 1'b0;
endtask

task automatic lsu_read(input logic [31:0] addr, input logic [3:0] id,
                        output logic [31:0] data, output resp_e resp, output logic [3:0] rid);
  lsu_ar_valid = 1'b1;
  lsu_ar_addr  = addr;
  lsu_ar_id    = id;
  lsu_ar_len   = 8'd0;
  lsu_ar_size  = 3'd2;
  lsu_ar_burst = BURST_INCR;
  @(negedge clock);
  while (!lsu_ar_ready) @(negedge clock);
  @(posedge clock);
  #1;
  lsu_ar_valid = 1'b0;
  lsu_r_ready  = 1'b1;
  @(negedge clock);
  while (!lsu_r_valid) @(negedge clock);
  data = lsu_r_data;
  resp = resp_e'(lsu_r_resp);
  rid  = lsu_r_id;
  check_flag(lsu_r_last, 1'b1, "lsu read last");      // Single beat is also the last
  @(posedge clock);
  #1;
  lsu_r_ready = 1'b0;
endtask

task automatic icache_burst_read(input logic [31:0] addr, input logic [7:0] len,
                                 input logic [3:0] id, input logic stall);
  int   gap;
  logic done;
  beat_data.delete();
  beat_resp.delete();
  beat_last.delete();
  beat_id.delete();
  icache_ar_valid = 1'b1;
  icache_ar_addr  = addr;
  icache_ar_id    = id;
  icache_ar_len   = len;
  icache_ar_size  = 3'd2;
  icache_ar_burst = BURST_INCR;
  @(negedge clock);
  while (!icache_ar_ready) @(negedge clock);
  @(posedge clock);
  #1;
  icache_ar_valid = 1'b0;
  done = 1'b0;
  while (!done) begin
    if (stall) begin
      icache_r_ready = 1'b0;                          // Random stretch of back-pressure
      gap = $unsigned($random(seed)) % 5;
      repeat (gap) begin
        @(posedge clock);
        #1;
      end
    end
    icache_r_ready = 1'b1;
    @(negedge clock);
    while (!icache_r_valid) @(negedge clock);
    beat_data.push_back(icache_r_data);
    beat_resp.push_back(resp_e'(icache_r_resp));
    beat_last.push_back(icache_r_last);
    beat_id.push_back(icache_r_id);
    done = icache_r_last || (beat_data.size() > len);
    @(posedge clock);
    #1;
  end
  icache_r_ready = 1'b0;
endtask

/* tb_mem_subsystem.sv */
module tb_mem_subsystem
  import mem_pkg::*;
();

  localparam int          TIMEOUT_CYCLES = 4000;
  localparam int          INIT_WORDS     = 32;
  localparam logic [31:0] MTIME_VALUE    = 32'h0012_3400;
  localparam logic [31:0] MTIME_HI_VALUE = 32'h0000_0042;

  logic        clock;
  logic        reset;
  logic        icache_ar_valid;
  logic [31:0] icache_ar_addr;
  logic [3:0]  icache_ar_id;
  logic [7:0]  icache_ar_len;
  logic [2:0]  icache_ar_size;
  logic [1:0]  icache_ar_burst;
  logic        icache_r_ready;
  logic        icache_ar_ready;
  logic        icache_r_valid;
  logic [31:0] icache_r_data;
  logic [1:0]  icache_r_resp;
  logic        icache_r_last;
  logic [3:0]  icache_r_id;
  logic        lsu_ar_valid;
  logic [31:0] lsu_ar_addr;
  logic [3:0]  lsu_ar_id;
  logic [7:0]  lsu_ar_len;
  logic [2:0]  lsu_ar_size;
  logic [1:0]  lsu_ar_burst;
  logic        lsu_r_ready;
  logic        lsu_aw_valid;
  logic [31:0] lsu_aw_addr;
  logic [3:0]  lsu_aw_id;
  logic [7:0]  lsu_aw_len;
  logic [2:0]  lsu_aw_size;
  logic [1:0]  lsu_aw_burst;
  logic        lsu_w_valid;
  logic [31:0] lsu_w_data;
  logic [3:0]  lsu_w_strb;
  logic        lsu_w_last;
  logic        lsu_b_ready;
  logic        lsu_ar_ready;
  logic        lsu_r_valid;
  logic [31:0] lsu_r_data;
  logic [1:0]  lsu_r_resp;
  logic        lsu_r_last;
  logic [3:0]  lsu_r_id;
  logic        lsu_aw_ready;
  logic        lsu_w_ready;
  logic        lsu_b_valid;
  logic [1:0]  lsu_b_resp;
  logic [3:0]  lsu_b_id;

  integer      seed;
  int          cycle_count;
  logic        watch_lsu;
  logic [31:0] shadow [SRAM_WORDS];                   // Reference copy of the SRAM
  int          data_errors;
  int          resp_errors;
  int          id_errors;
  int          flag_errors;
  int          other_errors;

  mem_subsystem UUT (.*);

  `include "tb_bus_tasks.svh"

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // ========================================
  // Compare tasks and reference rules
  // ========================================
  task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, msg, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_resp(input resp_e got, input resp_e exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
      resp_errors++;
    end
  endtask

  task automatic check_id(input logic [3:0] got, input logic [3:0] exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, msg, got, exp);
      id_errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %b expected %b", $time, msg, got, exp);
      flag_errors++;
    end
  endtask

  task automatic check_mtime(input logic [31:0] got, input logic [31:0] lo,
                             input logic [31:0] hi, input string msg);
    if (got < lo || got > hi) begin
      $display("** Error at %0t: %s got %h expected %h..%h", $time, msg, got, lo, hi);
      data_errors++;
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) result[8*b +: 8] = data[8*b +: 8];
    end
    return result;
  endfunction

  task automatic verify_burst(input int start, input int beats, input logic [3:0] id);
    if (beat_data.size() != beats) begin
      $display("Burst at word %0d returned %0d beats instead of %0d", start,
               beat_data.size(), beats);
      other_errors++;
    end else begin
      for (int i = 0; i < beats; i++) begin
        check_data(beat_data[i], shadow[start + i], "icache beat data");
        check_flag(beat_last[i], i == beats - 1, "icache beat last");
        check_id(beat_id[i], id, "icache beat id");
        check_resp(beat_resp[i], RESP_OKAY, "icache beat resp");
      end
    end
  endtask

  // Load/store must see no ready or valid while the icache owns the bus
  always @(negedge clock) begin
    if (watch_lsu) begin
      check_flag(lsu_ar_ready, 1'b0, "lsu_ar_ready during icache burst");
      check_flag(lsu_r_valid, 1'b0, "lsu_r_valid during icache burst");
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // ========================================
  // Directed tests
  // ========================================
  task automatic drive_idle();
    {icache_ar_valid, icache_ar_addr, icache_ar_id, icache_ar_len} = '0;
    {icache_ar_size, icache_ar_burst, icache_r_ready} = '0;
    {lsu_ar_valid, lsu_ar_addr, lsu_ar_id, lsu_ar_len, lsu_ar_size, lsu_ar_burst} = '0;
    {lsu_aw_valid, lsu_aw_addr, lsu_aw_id, lsu_aw_len, lsu_aw_size, lsu_aw_burst} = '0;
    {lsu_w_valid, lsu_w_data, lsu_w_strb, lsu_w_last, lsu_r_ready, lsu_b_ready} = '0;
  endtask

  task automatic init_sram();
    resp_e      resp;
    logic [3:0] bid;
    for (int i = 0; i < INIT_WORDS; i++) begin
      shadow[i] = fill_word(SRAM_BASE + 32'(i * 4));
      lsu_write(SRAM_BASE + 32'(i * 4), shadow[i], 4'hf, 4'h0, resp, bid);
      check_resp(resp, RESP_OKAY, "fill write resp");
    end
  endtask

  task automatic test_strobe_writes();
    int          idx;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [3:0]  rid;
    resp_e       resp;
    for (int i = 0; i < 8; i++) begin
      idx  = i * 3;
      data = $random(seed);
      strb = 4'($random(seed));
      lsu_write(SRAM_BASE + 32'(idx * 4), data, strb, 4'(i), resp, rid);
      check_resp(resp, RESP_OKAY, "strobe write resp");
      check_id(rid, 4'(i), "strobe write bid");
      shadow[idx] = merge_bytes(shadow[idx], data, strb);
    end
    for (int i = 0; i < 8; i++) begin
      idx = i * 3;
      lsu_read(SRAM_BASE + 32'(idx * 4), 4'(i + 8), data, resp, rid);
      check_data(data, shadow[idx], "strobe read data");
      check_resp(resp, RESP_OKAY, "strobe read resp");
      check_id(rid, 4'(i + 8), "strobe read rid");
    end
  endtask

  task automatic test_contention();
    logic [31:0] data;
    logic [3:0]  rid;
    resp_e       resp;
    watch_lsu = 1'b1;
    fork
      begin
        icache_burst_read(SRAM_BASE + 32'h20, 8'd3, 4'h3, 1'b0);
        watch_lsu = 1'b0;
      end
      lsu_read(SRAM_BASE + 32'h8, 4'h6, data, resp, rid);
    join
    verify_burst(8, 4, 4'h3);
    check_data(data, shadow[2], "lsu read after icache burst");
    check_resp(resp, RESP_OKAY, "lsu read resp after icache burst");
    check_id(rid, 4'h6, "lsu read rid after icache burst");
  endtask

  task automatic test_mtime();
    logic [31:0] first;
    logic [31:0] second;
    logic [3:0]  rid;
    resp_e       resp;
    int          start;
    start = cycle_count;
    lsu_write(MTIME_LO_ADDR, MTIME_VALUE, 4'hf, 4'h1, resp, rid);
    check_resp(resp, RESP_OKAY, "mtime write resp");
    check_id(rid, 4'h1, "mtime write bid");
    lsu_read(MTIME_LO_ADDR, 4'h2, first, resp, rid);
    check_mtime(first, MTIME_VALUE, MTIME_VALUE + 32'(cycle_count - start), "mtime low read");
    check_resp(resp, RESP_OKAY, "mtime read resp");
    check_id(rid, 4'h2, "mtime read rid");
    lsu_read(MTIME_LO_ADDR, 4'h3, second, resp, rid);
    check_flag(second > first, 1'b1, "mtime advances between reads");
    lsu_write(MTIME_HI_ADDR, MTIME_HI_VALUE, 4'hf, 4'h4, resp, rid);
    check_resp(resp, RESP_OKAY, "mtime high write resp");
    lsu_read(MTIME_HI_ADDR, 4'h5, first, resp, rid);
    check_data(first, MTIME_HI_VALUE, "mtime high read");
  endtask

  task automatic test_out_of_range();
    logic [31:0] data;
    logic [3:0]  rid;
    resp_e       resp;
    lsu_write(SRAM_BASE + 32'h1000, 32'hdead_beef, 4'hf, 4'h7, resp, rid);  // Aliases word 0
    check_resp(resp, RESP_DECERR, "write above SRAM resp");
    check_id(rid, 4'h7, "write above SRAM bid");
    lsu_write(32'h7fff_f004, 32'hcafe_f00d, 4'hf, 4'h8, resp, rid);  // Aliases word 1
    check_resp(resp, RESP_DECERR, "write below SRAM resp");
    lsu_read(SRAM_BASE + 32'h1004, 4'h9, data, resp, rid);
    check_resp(resp, RESP_DECERR, "read above SRAM resp");
    check_data(data, 32'h0, "read above SRAM data");
    check_id(rid, 4'h9, "read above SRAM rid");
    for (int i = 0; i < 2; i++) begin
      lsu_read(SRAM_BASE + 32'(i * 4), 4'ha, data, resp, rid);
      check_data(data, shadow[i], "word after rejected write");
    end
  endtask

  initial begin
    seed      = 32'hf6a3a18a;
    watch_lsu = 1'b0;
    drive_idle();
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    init_sram();
    test_strobe_writes();
    icache_burst_read(SRAM_BASE + 32'h10, 8'd7, 4'h5, 1'b0);
    verify_burst(4, 8, 4'h5);
    test_contention();
    test_mtime();
    test_out_of_range();
    icache_burst_read(SRAM_BASE + 32'h50, 8'd7, 4'ha, 1'b1);  // Back-pressured burst
    verify_burst(20, 8, 4'ha);
    $display("Errors: data %0d, resp %0d, id %0d, flag %0d, other %0d",
             data_errors, resp_errors, id_errors, flag_errors, other_errors);
    if (data_errors + resp_errors + id_errors + flag_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
